/* Bender.yml */
package:
  name: lpif_link

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/lpif_link_pkg.sv
      - logic/ll_word_if.sv
      - logic/ll_link_ctrl.sv
      - logic/lpif_pack.sv
      - logic/lpif_unpack.sv
      - logic/phy_lane_map.sv
      - logic/phy_lane_demap.sv
      - logic/lpif_link_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/lpif_link_tb.sv

/* compile.f */
+incdir+include
logic/lpif_link_pkg.sv
logic/ll_word_if.sv
logic/ll_link_ctrl.sv
logic/lpif_pack.sv
logic/lpif_unpack.sv
logic/phy_lane_map.sv
logic/phy_lane_demap.sv
logic/lpif_link_top.sv
dv/lpif_link_tb.sv

/* dv/lpif_link_tb.sv */
/*
  LPIF link adapter testbench
  External loopback, random traffic in gen1 and gen2, checked against a cycle model
*/
`timescale 1ns/100ps
`include "lpif_link_consts.svh"

module lpif_link_tb
  import lpif_link_pkg::*;
();

  // Online phase covers all delays plus traffic
  localparam int ONLINE_CYCLES  = 200;
  localparam int STIM_CYCLES    = 10 + 20 + 2 * ONLINE_CYCLES + 2 * 8;
  // Largest x + y + z per bring-up times two bring-ups
  localparam int MAX_DELAYS     = 2 * (11 + 8 + 26);
  localparam int TIMEOUT_CYCLES = STIM_CYCLES + MAX_DELAYS + 100;

  logic                   clk_wr;
  logic                   arst_n;
  logic                   tx_online;
  logic                   rx_online;
  logic                   m_gen2_mode;
  logic [`LL_DELAY_W-1:0] delay_x_value;
  logic [`LL_DELAY_W-1:0] delay_y_value;
  logic [`LL_DELAY_W-1:0] delay_z_value;
  logic [`LL_PHY_W-1:0]   tx_phy0;
  logic [`LL_PHY_W-1:0]   tx_phy1;
  logic [`LL_PHY_W-1:0]   rx_phy0;
  logic [`LL_PHY_W-1:0]   rx_phy1;
  ll_state_t              dstrm_state;
  ll_protid_t             dstrm_protid;
  logic [63:0]            dstrm_data;
  logic                   dstrm_dvalid;
  ll_crc_t                dstrm_crc;
  logic                   dstrm_crc_valid;
  logic                   dstrm_valid;
  ll_state_t              ustrm_state;
  ll_protid_t             ustrm_protid;
  logic [63:0]            ustrm_data;
  logic                   ustrm_dvalid;
  ll_crc_t                ustrm_crc;
  logic                   ustrm_crc_valid;
  logic                   ustrm_valid;
  logic [`LL_DBG_W-1:0]   tx_downstream_debug_status;
  logic [`LL_DBG_W-1:0]   rx_upstream_debug_status;
  ll_word_t               ustrm_word;

  // Stimulus selection
  logic [`LL_DELAY_W-1:0] dly_x;
  logic [`LL_DELAY_W-1:0] dly_y;
  logic [`LL_DELAY_W-1:0] dly_z;
  logic                   gen2_sel;

  // Model state as of the last modelled edge
  int                     ton_cnt;
  int                     ron_cnt;
  int                     tod_cnt;
  logic                   m_tod;
  logic                   m_rod;
  logic                   m_stb;
  ll_word_t               m_word;
  ll_word_t               exp_ustrm;
  ll_word_t               pipe_q[$];
  logic [`LL_PHY_W-1:0]   exp_phy0;
  logic [`LL_PHY_W-1:0]   exp_phy1;
  logic [`LL_DBG_W-1:0]   sent_model;
  logic [`LL_DBG_W-1:0]   acc_model;

  // Bring-up observation
  int                     iter_cnt;
  int                     on_iter;
  int                     mrk_iter;
  int                     stb_hits;
  int                     cycle_cnt;

  always #5 clk_wr = ~clk_wr;

  // External loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  assign ustrm_word = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                       ustrm_crc, ustrm_crc_valid, ustrm_valid};

  lpif_link_top i_lpif_link_top (.*);

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on first failure");
  endtask

  task automatic compare_word(input string name, input ll_word_t got, input ll_word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_phy(input string name, input logic [`LL_PHY_W-1:0] got,
                             input logic [`LL_PHY_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input logic [`LL_DBG_W-1:0] got,
                               input logic [`LL_DBG_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Expected channel layout while online with the marker set
  // Gen1 puts the marker at 39 and the strobe at 1
  // Gen2 puts the marker at 38 and the strobe at 0
  function automatic logic [`LL_PHY_W-1:0] lane_layout(
    input logic [`LL_LANE_DATA_W-1:0] bits,
    input logic                       stb,
    input logic                       gen2
  );
    logic [`LL_PHY_W-1:0] phy;
    if (gen2) begin
      phy = {bits[`LL_LANE_DATA_W-1], 1'b1, bits[`LL_LANE_DATA_W-2:0], stb};
    end else begin
      phy = {1'b1, bits[`LL_LANE_DATA_W-1:1], stb, bits[0]};
    end
    return phy;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Cycle model run right after each rising edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic model_step();
    ll_word_t link_word;
    ll_word_t rx_word_exp;
    // Map register output from last cycle's word and qualifiers
    exp_phy0 = m_tod ? lane_layout(m_word[`LL_LANE_DATA_W-1:0], m_stb, m_gen2_mode) : '0;
    exp_phy1 = m_tod ? lane_layout({1'b0, m_word[`LL_WORD_W-1:`LL_LANE_DATA_W]}, m_stb,
                                   m_gen2_mode) : '0;
    if (m_tod && m_word.valid) begin
      sent_model++;
    end
    // Only online words after training survive the link
    link_word = (m_tod && !m_stb && m_word.valid) ? m_word : '0;
    pipe_q.push_back(link_word);
    rx_word_exp = pipe_q.pop_front();
    exp_ustrm = m_rod ? rx_word_exp : '0;
    if (exp_ustrm.valid) begin
      acc_model++;
    end
    // Online delays and training window from sampled inputs
    ton_cnt = tx_online ? ton_cnt + 1 : 0;
    ron_cnt = rx_online ? ron_cnt + 1 : 0;
    m_tod   = tx_online && (ton_cnt > delay_y_value);
    m_rod   = rx_online && (ron_cnt > delay_x_value);
    tod_cnt = m_tod ? tod_cnt + 1 : 0;
    m_stb   = m_tod && (tod_cnt <= delay_z_value);
    m_word  = dstrm_valid ? {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                             dstrm_crc, dstrm_crc_valid, 1'b1} : '0;
  endtask

  task automatic drive_inputs(input logic tx_on, input logic rx_on);
    // About one word in four goes out with valid clear
    dstrm_valid     <= ($urandom % 4) != 0;
    dstrm_state     <= $urandom;
    dstrm_protid    <= $urandom;
    dstrm_data      <= {$urandom, $urandom};
    dstrm_dvalid    <= $urandom;
    dstrm_crc       <= $urandom;
    dstrm_crc_valid <= $urandom;
    tx_online       <= tx_on;
    rx_online       <= rx_on;
    m_gen2_mode     <= gen2_sel;
    delay_x_value   <= dly_x;
    delay_y_value   <= dly_y;
    delay_z_value   <= dly_z;
  endtask

  task automatic check_outputs();
    compare_phy("tx_phy0", tx_phy0, exp_phy0);
    compare_phy("tx_phy1", tx_phy1, exp_phy1);
    compare_word("ustrm", ustrm_word, exp_ustrm);
    compare_count("tx_downstream_debug_status", tx_downstream_debug_status, sent_model);
    compare_count("rx_upstream_debug_status", rx_upstream_debug_status, acc_model);
    if (tx_phy0[gen2_sel ? `LL_STB_POS_G2 : `LL_STB_POS_G1]) begin
      stb_hits++;
    end
    if (tx_phy0[gen2_sel ? `LL_MRK_POS_G2 : `LL_MRK_POS_G1] && (mrk_iter < 0)) begin
      mrk_iter = iter_cnt;
    end
  endtask

  // Drive on the rising edge and check at the falling edge
  task automatic run_cycles(input int n, input logic tx_on, input logic rx_on);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_wr);
      iter_cnt++;
      model_step();
      drive_inputs(tx_on, rx_on);
      @(negedge clk_wr);
      check_outputs();
    end
  endtask

  task automatic bring_up(input logic gen2);
    gen2_sel = gen2;
    dly_y    = 16'(4 + $urandom % 8);
    dly_z    = 16'(3 + $urandom % 6);
    // RX comes up after training so early words get dropped
    dly_x    = 16'(dly_y + dly_z + 2 + $urandom % 6);
    stb_hits = 0;
    mrk_iter = -1;
    on_iter  = iter_cnt + 1;
    run_cycles(ONLINE_CYCLES, 1'b1, 1'b1);
    // Y cycles after tx_online is seen plus the input and map registers
    compare_count("marker delay", mrk_iter - on_iter, dly_y + 2);
    compare_count("strobe length", stb_hits, dly_z);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk_wr) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    clk_wr          = 1'b0;
    arst_n          = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    m_gen2_mode     = 1'b0;
    delay_x_value   = '0;
    delay_y_value   = '0;
    delay_z_value   = '0;
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
    dly_x           = '0;
    dly_y           = '0;
    dly_z           = '0;
    gen2_sel        = 1'b0;
    ton_cnt         = 0;
    ron_cnt         = 0;
    tod_cnt         = 0;
    m_tod           = 1'b0;
    m_rod           = 1'b0;
    m_stb           = 1'b0;
    m_word          = '0;
    sent_model      = '0;
    acc_model       = '0;
    iter_cnt        = 0;
    cycle_cnt       = 0;
    void'($urandom(19753));
    // Map and demap stages between the link word and ustrm
    pipe_q.push_back('0);
    pipe_q.push_back('0);

    repeat (10) @(posedge clk_wr);
    arst_n <= 1'b1;

    // Offline traffic must not leak anywhere
    run_cycles(20, 1'b0, 1'b0);
    bring_up(1'b0);
    run_cycles(8, 1'b0, 1'b0);
    bring_up(1'b1);
    // Drain
    run_cycles(8, 1'b0, 1'b0);

    compare_count("tx_downstream_debug_status", tx_downstream_debug_status, sent_model);
    compare_count("rx_upstream_debug_status", rx_upstream_debug_status, acc_model);
    if (acc_model == 0) begin
      report_failure("No word was accepted, traffic never reached the upstream side");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* include/lpif_link_consts.svh */
/*
  LPIF link adapter constants
  Widths, channel bit positions and counter sizes
*/
`ifndef LPIF_LINK_CONSTS_SVH
`define LPIF_LINK_CONSTS_SVH

// Link word and PHY channel widths
`define LL_WORD_W        75
`define LL_PHY_W         40
`define LL_LANE_DATA_W   38

// Strobe and marker slots, gen1 then gen2
`define LL_STB_POS_G1    1
`define LL_MRK_POS_G1    39
`define LL_STB_POS_G2    0
`define LL_MRK_POS_G2    38

// Delay values and debug counters
`define LL_DELAY_W       16
`define LL_DBG_W         32

`endif

/* logic/ll_link_ctrl.sv */
/*
  Link bring-up control
  Online delays, training window, strobe and marker generation
*/
`timescale 1ns/100ps
`include "lpif_link_consts.svh"

module ll_link_ctrl (
  input  logic                   clk_wr,
  input  logic                   arst_n,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [`LL_DELAY_W-1:0] delay_x_value,
  input  logic [`LL_DELAY_W-1:0] delay_y_value,
  input  logic [`LL_DELAY_W-1:0] delay_z_value,
  ll_word_if.src                 tx_word,
  output logic                   rx_online_delay
);

  // Index 0 is TX (delay_y), index 1 is RX (delay_x)
  logic                   online_in  [2];
  logic [`LL_DELAY_W-1:0] delay_val  [2];
  logic [`LL_DELAY_W-1:0] delay_cnt  [2];
  logic                   online_dly [2];

  // Training window counter
  logic [`LL_DELAY_W-1:0] train_cnt;
  logic                   train_active;

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_val[0] = delay_y_value;
  assign delay_val[1] = delay_x_value;

  ////////////////////////////////////////////////////////////////////////////
  // Online delays
  ////////////////////////////////////////////////////////////////////////////
  for (genvar g = 0; g < 2; g++) begin : g_delay
    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        delay_cnt[g]  <= '0;
        online_dly[g] <= 1'b0;
      end else if (!online_in[g]) begin
        // Drop straight away, restart count
        delay_cnt[g]  <= '0;
        online_dly[g] <= 1'b0;
      end else if (delay_cnt[g] >= delay_val[g]) begin
        online_dly[g] <= 1'b1;
      end else begin
        delay_cnt[g]  <= delay_cnt[g] + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Training window
  ////////////////////////////////////////////////////////////////////////////
  // Counts the first delay_z cycles of TX online, then holds
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      train_cnt <= '0;
    end else if (!online_dly[0]) begin
      train_cnt <= '0;
    end else if (train_cnt < delay_z_value) begin
      train_cnt <= train_cnt + 1'b1;
    end
  end

  assign train_active = online_dly[0] && (train_cnt < delay_z_value);

  // TX qualifiers, marker persists while online
  assign tx_word.online  = online_dly[0];
  assign tx_word.stb     = train_active;
  assign tx_word.mrk     = online_dly[0];

  assign rx_online_delay = online_dly[1];

endmodule

/* logic/ll_word_if.sv */
/*
  Link word bundle
  Word plus online, strobe and marker between pack/map stages
*/
`timescale 1ns/100ps

interface ll_word_if
  import lpif_link_pkg::*;
();

  // Payload
  ll_word_t word;

  // Link qualifiers
  logic     online;
  logic     stb;
  logic     mrk;

  // Producer side, possibly split over several drivers
  modport src  (output word, output online, output stb, output mrk);
  // Consumer side
  modport sink (input word, input online, input stb, input mrk);

endinterface

/* logic/lpif_link_pkg.sv */
/*
  LPIF link adapter types
  Stream field types and the packed link word
*/
package lpif_link_pkg;

  // Stream state, as seen on dstrm/ustrm
  typedef logic [3:0] ll_state_t;

  // Protocol id
  typedef logic [1:0] ll_protid_t;

  // CRC bits, carried only
  typedef logic [1:0] ll_crc_t;

  ////////////////////////////////////////////////////////////////////////////
  // Link word, 75 bits, MSB first
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    ll_state_t   state;
    ll_protid_t  protid;
    logic [63:0] data;
    logic        dvalid;
    ll_crc_t     crc;
    logic        crc_valid;
    // Word qualifier, bit 0 of the link word
    logic        valid;
  } ll_word_t;

endpackage

/* logic/lpif_link_top.sv */
/*
  LPIF logic-link adapter top
  One stream over two 40-bit PHY channels, single clock
*/
`timescale 1ns/100ps
`include "lpif_link_consts.svh"

module lpif_link_top
  import lpif_link_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   arst_n,
  // Link control
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic                   m_gen2_mode,
  input  logic [`LL_DELAY_W-1:0] delay_x_value,
  input  logic [`LL_DELAY_W-1:0] delay_y_value,
  input  logic [`LL_DELAY_W-1:0] delay_z_value,
  // PHY channels
  output logic [`LL_PHY_W-1:0]   tx_phy0,
  output logic [`LL_PHY_W-1:0]   tx_phy1,
  input  logic [`LL_PHY_W-1:0]   rx_phy0,
  input  logic [`LL_PHY_W-1:0]   rx_phy1,
  // Downstream
  input  ll_state_t              dstrm_state,
  input  ll_protid_t             dstrm_protid,
  input  logic [63:0]            dstrm_data,
  input  logic                   dstrm_dvalid,
  input  ll_crc_t                dstrm_crc,
  input  logic                   dstrm_crc_valid,
  input  logic                   dstrm_valid,
  // Upstream
  output ll_state_t              ustrm_state,
  output ll_protid_t             ustrm_protid,
  output logic [63:0]            ustrm_data,
  output logic                   ustrm_dvalid,
  output ll_crc_t                ustrm_crc,
  output logic                   ustrm_crc_valid,
  output logic                   ustrm_valid,
  // Debug
  output logic [`LL_DBG_W-1:0]   tx_downstream_debug_status,
  output logic [`LL_DBG_W-1:0]   rx_upstream_debug_status
);

  logic rx_online_delay;

  ll_word_if tx_word ();
  ll_word_if rx_word ();

  // RX online comes from the control block
  assign rx_word.online = rx_online_delay;

  ////////////////////////////////////////////////////////////////////////////
  // Bring-up control
  ////////////////////////////////////////////////////////////////////////////
  ll_link_ctrl i_ll_link_ctrl (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_word         (tx_word.src),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////////////////////
  lpif_pack i_lpif_pack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_word         (tx_word.src)
  );

  phy_lane_map i_phy_lane_map (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .m_gen2_mode (m_gen2_mode),
    .tx_word     (tx_word.sink),
    .tx_phy0     (tx_phy0),
    .tx_phy1     (tx_phy1),
    .sent_count  (tx_downstream_debug_status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////////////////////
  phy_lane_demap i_phy_lane_demap (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .m_gen2_mode (m_gen2_mode),
    .rx_phy0     (rx_phy0),
    .rx_phy1     (rx_phy1),
    .rx_word     (rx_word.src)
  );

  lpif_unpack i_lpif_unpack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .rx_word         (rx_word.sink),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .accept_count    (rx_upstream_debug_status)
  );

endmodule

/* logic/lpif_pack.sv */
/*
  Downstream packer
  Registers the dstrm fields into one link word
*/
`timescale 1ns/100ps

module lpif_pack
  import lpif_link_pkg::*;
(
  input  logic        clk_wr,
  input  logic        arst_n,
  input  ll_state_t   dstrm_state,
  input  ll_protid_t  dstrm_protid,
  input  logic [63:0] dstrm_data,
  input  logic        dstrm_dvalid,
  input  ll_crc_t     dstrm_crc,
  input  logic        dstrm_crc_valid,
  input  logic        dstrm_valid,
  ll_word_if.src      tx_word
);

  ll_word_t word_d;

  // Idle words go out as all zero
  always_comb begin
    word_d = '0;
    if (dstrm_valid) begin
      word_d.state     = dstrm_state;
      word_d.protid    = dstrm_protid;
      word_d.data      = dstrm_data;
      word_d.dvalid    = dstrm_dvalid;
      word_d.crc       = dstrm_crc;
      word_d.crc_valid = dstrm_crc_valid;
      word_d.valid     = 1'b1;
    end
  end

  // Pack stage, first of two TX cycles
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_word.word <= '0;
    end else begin
      tx_word.word <= word_d;
    end
  end

endmodule

/* logic/lpif_unpack.sv */
/*
  Upstream unpacker
  Filters received words onto ustrm and counts accepted ones
*/
`timescale 1ns/100ps
`include "lpif_link_consts.svh"

module lpif_unpack
  import lpif_link_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 arst_n,
  ll_word_if.sink              rx_word,
  output ll_state_t            ustrm_state,
  output ll_protid_t           ustrm_protid,
  output logic [63:0]          ustrm_data,
  output logic                 ustrm_dvalid,
  output ll_crc_t              ustrm_crc,
  output logic                 ustrm_crc_valid,
  output logic                 ustrm_valid,
  output logic [`LL_DBG_W-1:0] accept_count
);

  ll_word_t rx_w;
  ll_word_t ustrm_q;
  logic     accept;

  assign rx_w = rx_word.word;

  // Receive rule
  // Online, out of training, and a valid word
  assign accept = rx_word.online && !rx_word.stb && rx_w.valid;

  ////////////////////////////////////////////////////////////////////////////
  // Upstream register and accept counter
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      ustrm_q      <= '0;
      accept_count <= '0;
    end else begin
      // Rejected words show as zero upstream
      ustrm_q <= accept ? rx_w : '0;
      if (accept) begin
        accept_count <= accept_count + 1'b1;
      end
    end
  end

  // Field split
  assign ustrm_state     = ustrm_q.state;
  assign ustrm_protid    = ustrm_q.protid;
  assign ustrm_data      = ustrm_q.data;
  assign ustrm_dvalid    = ustrm_q.dvalid;
  assign ustrm_crc       = ustrm_q.crc;
  assign ustrm_crc_valid = ustrm_q.crc_valid;
  assign ustrm_valid     = ustrm_q.valid;

endmodule

/* logic/phy_lane_demap.sv */
/*
  RX lane demapper
  Rebuilds the link word and strobe from two PHY channels
*/
`timescale 1ns/100ps
`include "lpif_link_consts.svh"

module phy_lane_demap
  import lpif_link_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  logic                 m_gen2_mode,
  input  logic [`LL_PHY_W-1:0] rx_phy0,
  input  logic [`LL_PHY_W-1:0] rx_phy1,
  ll_word_if.src               rx_word
);

  logic [`LL_LANE_DATA_W-1:0] lane0;
  logic [`LL_LANE_DATA_W-1:0] lane1;
  logic [`LL_WORD_W-1:0]      word_bits;
  logic                       stb_d;

  // Skips strobe and marker slots and keeps the rest in ascending order
  function automatic logic [`LL_LANE_DATA_W-1:0] extract_lane(
    input logic [`LL_PHY_W-1:0] phy,
    input int unsigned          stb_pos,
    input int unsigned          mrk_pos
  );
    logic [`LL_LANE_DATA_W-1:0] lane;
    int unsigned                k;
    lane = '0;
    k    = 0;
    for (int unsigned i = 0; i < `LL_PHY_W; i++) begin
      if ((i != stb_pos) && (i != mrk_pos)) begin
        lane[k] = phy[i];
        k++;
      end
    end
    return lane;
  endfunction

  // Layout select with the strobe taken from channel 0 only
  always_comb begin
    if (m_gen2_mode) begin
      lane0 = extract_lane(rx_phy0, `LL_STB_POS_G2, `LL_MRK_POS_G2);
      lane1 = extract_lane(rx_phy1, `LL_STB_POS_G2, `LL_MRK_POS_G2);
      stb_d = rx_phy0[`LL_STB_POS_G2];
    end else begin
      lane0 = extract_lane(rx_phy0, `LL_STB_POS_G1, `LL_MRK_POS_G1);
      lane1 = extract_lane(rx_phy1, `LL_STB_POS_G1, `LL_MRK_POS_G1);
      stb_d = rx_phy0[`LL_STB_POS_G1];
    end
  end

  // Top slot of channel 1 carries nothing
  assign word_bits = {lane1[`LL_WORD_W-`LL_LANE_DATA_W-1:0], lane0};

  // Strobe register
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_word.stb <= 1'b0;
    end else begin
      rx_word.stb <= stb_d;
    end
  end

  // Word register as the first of two RX cycles
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_word.word <= '0;
    end else begin
      rx_word.word <= ll_word_t'(word_bits);
    end
  end

  // No marker on the receive side
  assign rx_word.mrk = 1'b0;

endmodule

/* logic/phy_lane_map.sv */
/*
  TX lane mapper
  Spreads a link word over two PHY channels with strobe and marker
*/
`timescale 1ns/100ps
`include "lpif_link_consts.svh"

module phy_lane_map
  import lpif_link_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  logic                 m_gen2_mode,
  ll_word_if.sink              tx_word,
  output logic [`LL_PHY_W-1:0] tx_phy0,
  output logic [`LL_PHY_W-1:0] tx_phy1,
  output logic [`LL_DBG_W-1:0] sent_count
);

  ll_word_t                   tx_w;
  logic [`LL_LANE_DATA_W-1:0] lane0;
  logic [`LL_LANE_DATA_W-1:0] lane1;
  logic [`LL_PHY_W-1:0]       phy0_d;
  logic [`LL_PHY_W-1:0]       phy1_d;
  logic                       word_sent;

  // Lane bits fill the free slots in ascending order
  function automatic logic [`LL_PHY_W-1:0] place_lane(
    input logic [`LL_LANE_DATA_W-1:0] lane,
    input logic                       stb,
    input logic                       mrk,
    input int unsigned                stb_pos,
    input int unsigned                mrk_pos
  );
    logic [`LL_PHY_W-1:0] phy;
    int unsigned          k;
    phy = '0;
    k   = 0;
    for (int unsigned i = 0; i < `LL_PHY_W; i++) begin
      if (i == stb_pos) begin
        phy[i] = stb;
      end else if (i == mrk_pos) begin
        phy[i] = mrk;
      end else begin
        phy[i] = lane[k];
        k++;
      end
    end
    return phy;
  endfunction

  assign tx_w = tx_word.word;

  // Channel 0 low bits, channel 1 the rest with top slot zero
  always_comb begin
    lane0 = tx_w[`LL_LANE_DATA_W-1:0];
    lane1 = '0;
    lane1[`LL_WORD_W-`LL_LANE_DATA_W-1:0] = tx_w[`LL_WORD_W-1:`LL_LANE_DATA_W];
  end

  // Mode select of the channel layout
  always_comb begin
    if (m_gen2_mode) begin
      phy0_d = place_lane(lane0, tx_word.stb, tx_word.mrk, `LL_STB_POS_G2, `LL_MRK_POS_G2);
      phy1_d = place_lane(lane1, tx_word.stb, tx_word.mrk, `LL_STB_POS_G2, `LL_MRK_POS_G2);
    end else begin
      phy0_d = place_lane(lane0, tx_word.stb, tx_word.mrk, `LL_STB_POS_G1, `LL_MRK_POS_G1);
      phy1_d = place_lane(lane1, tx_word.stb, tx_word.mrk, `LL_STB_POS_G1, `LL_MRK_POS_G1);
    end
  end

  assign word_sent = tx_word.online && tx_w.valid;

  ////////////////////////////////////////////////////////////////////////////
  // Output register, zero while offline
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0    <= '0;
      tx_phy1    <= '0;
      sent_count <= '0;
    end else begin
      tx_phy0 <= tx_word.online ? phy0_d : '0;
      tx_phy1 <= tx_word.online ? phy1_d : '0;
      if (word_sent) begin
        sent_count <= sent_count + 1'b1;
      end
    end
  end

endmodule
